// ==== ballPhysics.sv ====
`default_nettype none

`include "pinball_cfg.svh"

module ballPhysics
	import pinballPkg::*;
(
	input  logic    clk,
	input  logic    resetN,
	input  logic    startOfFrame,
	input  logic    pause,
	input  logic    levelReset,
	input  launchT  launch,
	input  hitT     wallHit,
	output ballPosT ballPos
);

	// ====================
	// Constants
	// ====================

	localparam fixPosT startXFix = fixPosT'(`START_X * `FIXED_SCALE);
	localparam fixPosT startYFix = fixPosT'(`START_Y * `FIXED_SCALE);

	// Right bound for the top-left corner in fixed units.
	localparam fixPosT fieldWFix = fixPosT'(`FIELD_W * `FIXED_SCALE);

	localparam speedT gravity = speedT'(`GRAVITY);

	// ====================
	// State
	// ====================

	speedT speedX;
	speedT speedY;

	fixPosT posX;
	fixPosT posY;

	// Candidate x for the coming tick.
	fixPosT nextX;
	logic   xOutOfField;

	always_comb begin
		nextX       = posX + fixPosT'(speedX);
		xOutOfField = (nextX < fixPosT'(0)) || (nextX > fieldWFix);
	end

	// ====================
	// Vertical axis
	// ====================

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speedY <= '0;
			posY   <= startYFix;
		end else if (levelReset) begin
			speedY <= '0;
			posY   <= startYFix;
		end else if (!pause) begin
			if (startOfFrame) begin
				// Move by the old speed, then gravity.
				speedY <= speedY + gravity;
				posY   <= posY + fixPosT'(speedY);
			end else if (launch.strobe) begin
				speedY <= -speedY + launch.speedY;
			end else if (wallHit.hit) begin
				// Top wall.
				if (wallHit.edges[2] && (speedY < speedT'(0))) begin
					speedY <= -speedY;
				end else if (wallHit.edges[0] && (speedY > speedT'(0))) begin
					// Floor.
					speedY <= -speedY;
				end
			end
		end
	end

	// ====================
	// Horizontal axis
	// ====================

	// The launcher only kicks upward, so x skips the launch branch.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speedX <= '0;
			posX   <= startXFix;
		end else if (levelReset) begin
			speedX <= '0;
			posX   <= startXFix;
		end else if (!pause) begin
			if (startOfFrame) begin
				if (xOutOfField) begin
					// Hold position, lose half the speed.
					speedX <= speedX >>> 1;
				end else begin
					posX <= nextX;
				end
			end else if (wallHit.hit) begin
				// Left wall.
				if (wallHit.edges[3] && (speedX < speedT'(0))) begin
					speedX <= -speedX;
				end else if (wallHit.edges[1] && (speedX > speedT'(0))) begin
					// Right wall.
					speedX <= -speedX;
				end
			end
		end
	end

	// ====================
	// Pixel position
	// ====================

	assign ballPos.x = coordT'(posX / `FIXED_SCALE);
	assign ballPos.y = coordT'(posY / `FIXED_SCALE);

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
pinballPkg.sv
frameTicker.sv
wallCollision.sv
ballPhysics.sv
pinballTop.sv
pinball_asserts.sv
pinballTb.sv

// ==== frameTicker.sv ====
`default_nettype none

`include "pinball_cfg.svh"

module frameTicker (
	input  logic clk,
	input  logic resetN,
	output logic startOfFrame
);

	localparam int cntWidth = $clog2(`FRAME_CYCLES);

	localparam logic [cntWidth-1:0] reloadValue = cntWidth'(`FRAME_CYCLES - 1);
	localparam logic [cntWidth-1:0] lastCount   = cntWidth'(1);

	logic [cntWidth-1:0] frameCnt;

	// Down counter, wraps from zero back to the reload value.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			frameCnt <= '0;
		end else if (frameCnt == '0) begin
			frameCnt <= reloadValue;
		end else begin
			frameCnt <= frameCnt - 1'b1;
		end
	end

	// High for the one cycle in which the counter wraps.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			startOfFrame <= 1'b0;
		end else begin
			startOfFrame <= (frameCnt == lastCount);
		end
	end

endmodule

`default_nettype wire

// ==== pinballPkg.sv ====
`default_nettype none

`include "pinball_cfg.svh"

package pinballPkg;

	// Speed in fixed units per frame.
	typedef logic signed [`SPEED_W-1:0] speedT;

	// Position in fixed units.
	typedef logic signed [23:0] fixPosT;

	// Pixel coordinate.
	typedef logic signed [`COORD_W-1:0] coordT;

	// Bit 3 left, bit 2 top, bit 1 right, bit 0 bottom.
	typedef logic [3:0] edgeCodeT;

	// Top-left corner of the ball box.
	typedef struct packed {
		coordT x;
		coordT y;
	} ballPosT;

	typedef struct packed {
		logic     hit;
		edgeCodeT edges;
	} hitT;

	// Single-cycle kick with a signed vertical speed.
	typedef struct packed {
		logic  strobe;
		speedT speedY;
	} launchT;

endpackage

`default_nettype wire

// ==== pinballTb.sv ====
`default_nettype none

`include "pinball_cfg.svh"

module pinballTb
	import pinballPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int maxRows = 8;

	// Row check flags.
	localparam logic [3:0] chkStart = 4'b1000;
	localparam logic [3:0] chkHold  = 4'b0100;
	localparam logic [3:0] chkXHold = 4'b0010;
	localparam logic [3:0] chkRise  = 4'b0001;

	typedef struct packed {
		logic       pauseLvl;
		logic       doReset;
		logic       doLaunch;
		speedT      launchMin;
		speedT      launchMax;
		logic [7:0] frames;
		logic [3:0] checks;
	} stimRowT;

	logic    clk;
	logic    resetN;
	logic    pause;
	logic    levelReset;
	launchT  launch;
	ballPosT ballPos;
	logic    startOfFrame;

	stimRowT stimTable [maxRows];
	int      rowCount;
	int      errorCount;
	int      checkCount;

	// Reference model state in fixed units.
	int         mCnt;
	logic       mTick;
	logic [3:0] mEdges;
	int         mVx;
	int         mVy;
	int         mX;
	int         mY;

	pinballTop DUT (
		.clk          (clk),
		.resetN       (resetN),
		.pause        (pause),
		.levelReset   (levelReset),
		.launch       (launch),
		.ballPos      (ballPos),
		.startOfFrame (startOfFrame)
	);

	always #4 clk = ~clk;

	// ====================
	// Reference model
	// ====================

	function automatic int toPixel(input int fix);
		return fix / `FIXED_SCALE;
	endfunction

	function automatic logic [3:0] wallEdges(input int px, input int py);
		logic [3:0] e;
		e[3] = (px <= 0);
		e[2] = (py <= 0);
		e[1] = (px + `BALL_SIZE >= `FIELD_W);
		e[0] = (py + `BALL_SIZE >= `FIELD_H);
		return e;
	endfunction

	always @(posedge clk or negedge resetN) begin : refModel
		logic       tickNow;
		logic [3:0] edgesNow;
		int         nextX;
		if (!resetN) begin
			mCnt   = 0;
			mTick  = 1'b0;
			mEdges = 4'b0000;
			mVx    = 0;
			mVy    = 0;
			mX     = `START_X * `FIXED_SCALE;
			mY     = `START_Y * `FIXED_SCALE;
		end else begin
			tickNow  = mTick;
			edgesNow = mEdges;
			mTick    = (mCnt == 1);
			mCnt     = (mCnt == 0) ? `FRAME_CYCLES - 1 : mCnt - 1;
			// Wall test sees the position before this edge.
			mEdges   = wallEdges(toPixel(mX), toPixel(mY));
			if (levelReset) begin
				mVx = 0;
				mVy = 0;
				mX  = `START_X * `FIXED_SCALE;
				mY  = `START_Y * `FIXED_SCALE;
			end else if (!pause) begin
				if (tickNow) begin
					mY    = mY + mVy;
					mVy   = mVy + `GRAVITY;
					nextX = mX + mVx;
					if ((nextX < 0) || (nextX > `FIELD_W * `FIXED_SCALE)) begin
						mVx = mVx >>> 1;
					end else begin
						mX = nextX;
					end
				end else begin
					if (launch.strobe) begin
						mVy = int'(launch.speedY) - mVy;
					end else if ((edgesNow[2] && mVy < 0) || (edgesNow[0] && mVy > 0)) begin
						mVy = -mVy;
					end
					// The x axis has no launch branch.
					if ((edgesNow[3] && mVx < 0) || (edgesNow[1] && mVx > 0)) begin
						mVx = -mVx;
					end
				end
			end
		end
	end

	// Frame pulse against the model on every cycle.
	always @(negedge clk) begin
		if (resetN && (startOfFrame !== mTick)) begin
			$display("[FAIL] startOfFrame expected %h actual %h", mTick, startOfFrame);
			errorCount++;
		end
	end

	// ====================
	// Helpers
	// ====================

	task automatic addRow(input logic pauseLvl, input logic doReset, input logic doLaunch,
		input int launchMin, input int launchMax, input int frames, input logic [3:0] checks);
		stimTable[rowCount].pauseLvl  = pauseLvl;
		stimTable[rowCount].doReset   = doReset;
		stimTable[rowCount].doLaunch  = doLaunch;
		stimTable[rowCount].launchMin = speedT'(launchMin);
		stimTable[rowCount].launchMax = speedT'(launchMax);
		stimTable[rowCount].frames    = 8'(frames);
		stimTable[rowCount].checks    = checks;
		rowCount++;
	endtask

	task automatic buildTable();
		addRow(0, 0, 0, 0, 0, 6, chkXHold);
		// Long enough to reach the floor and rise again.
		addRow(0, 0, 0, 0, 0, 24, chkXHold | chkRise);
		addRow(0, 0, 1, -320, -200, 8, chkXHold);
		// This launch is lost.
		addRow(1, 0, 1, -300, -100, 5, chkHold | chkXHold);
		addRow(0, 0, 0, 0, 0, 4, chkXHold);
		addRow(0, 1, 0, 0, 0, 6, chkStart | chkXHold);
		addRow(0, 0, 1, -280, -150, 10, chkXHold);
	endtask

	task automatic reportMismatch(input string name, input coordT expected, input coordT actual);
		$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		errorCount++;
	endtask

	task automatic waitTick(output int cycles);
		cycles = 1;
		@(negedge clk);
		while (startOfFrame !== 1'b1) begin
			@(negedge clk);
			cycles++;
		end
	endtask

	// Settles past the update, wall register and reflection.
	task automatic compareWithModel();
		coordT expX;
		coordT expY;
		repeat (3) @(negedge clk);
		expX = coordT'(toPixel(mX));
		expY = coordT'(toPixel(mY));
		checkCount++;
		if (ballPos.x !== expX) begin
			reportMismatch("ballPos.x", expX, ballPos.x);
		end
		if (ballPos.y !== expY) begin
			reportMismatch("ballPos.y", expY, ballPos.y);
		end
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin : mainSeq
		int      cycles;
		int      totalFrames;
		int      span;
		coordT   prevY;
		ballPosT holdPos;
		logic    rose;
		stimRowT row;
		void'($urandom(32'hb53b4b1c));
		clk        = 1'b0;
		resetN     = 1'b1;
		pause      = 1'b0;
		levelReset = 1'b0;
		launch     = '0;
		errorCount = 0;
		checkCount = 0;
		rowCount   = 0;
		buildTable();
		totalFrames = 1;
		for (int i = 0; i < rowCount; i++) begin
			totalFrames += stimTable[i].frames;
		end

		fork
			begin
				#((totalFrames + rowCount + 4) * `FRAME_CYCLES * 8);
				$display("Timeout: the ball sequence did not finish in time.");
				$display("Checks: %0d, errors: %0d", checkCount, errorCount + 1);
				$display("*** FAILED ***");
				$finish;
			end
		join_none

		// Falling edge clears every register before the first clock.
		#1;
		resetN = 1'b0;

		repeat (4) @(posedge clk);
		@(negedge clk);
		checkCount++;
		if (ballPos.x !== coordT'(`START_X)) begin
			reportMismatch("ballPos.x", coordT'(`START_X), ballPos.x);
		end
		if (ballPos.y !== coordT'(`START_Y)) begin
			reportMismatch("ballPos.y", coordT'(`START_Y), ballPos.y);
		end
		resetN = 1'b1;
		waitTick(cycles);
		checkCount++;
		if (cycles != `FRAME_CYCLES) begin
			$display("[FAIL] startOfFrame delay expected %h actual %h", `FRAME_CYCLES, cycles);
			errorCount++;
		end
		compareWithModel();

		for (int r = 0; r < rowCount; r++) begin
			row   = stimTable[r];
			pause = row.pauseLvl;
			if (row.doReset) begin
				levelReset = 1'b1;
				@(negedge clk);
				levelReset = 1'b0;
				if ((row.checks & chkStart) != 0) begin
					checkCount++;
					if (ballPos.x !== coordT'(`START_X)) begin
						reportMismatch("ballPos.x", coordT'(`START_X), ballPos.x);
					end
					if (ballPos.y !== coordT'(`START_Y)) begin
						reportMismatch("ballPos.y", coordT'(`START_Y), ballPos.y);
					end
				end
			end
			if (row.doLaunch) begin
				span          = int'(row.launchMax) - int'(row.launchMin) + 1;
				launch.speedY = speedT'(int'(row.launchMin) + int'($urandom % span));
				launch.strobe = 1'b1;
				@(negedge clk);
				launch = '0;
			end
			holdPos = ballPos;
			prevY   = ballPos.y;
			rose    = 1'b0;
			for (int f = 0; f < row.frames; f++) begin
				waitTick(cycles);
				compareWithModel();
				if (((row.checks & chkHold) != 0) && (ballPos.x !== holdPos.x)) begin
					reportMismatch("ballPos.x", holdPos.x, ballPos.x);
				end
				if (((row.checks & chkHold) != 0) && (ballPos.y !== holdPos.y)) begin
					reportMismatch("ballPos.y", holdPos.y, ballPos.y);
				end
				if (((row.checks & chkXHold) != 0) && (ballPos.x !== coordT'(`START_X))) begin
					reportMismatch("ballPos.x", coordT'(`START_X), ballPos.x);
				end
				if (ballPos.y < prevY) begin
					rose = 1'b1;
				end
				prevY = ballPos.y;
			end
			if (((row.checks & chkRise) != 0) && !rose) begin
				$display("The ball never moved up again after reaching the floor.");
				errorCount++;
			end
		end

		pause = 1'b0;
		repeat (2) @(negedge clk);
		errorCount += DUT.checks.failCount;
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== pinballTop.sv ====
`default_nettype none

module pinballTop
	import pinballPkg::*;
(
	input  logic    clk,
	input  logic    resetN,
	input  logic    pause,
	input  logic    levelReset,
	input  launchT  launch,
	output ballPosT ballPos,
	output logic    startOfFrame
);

	// Registered wall event back into the physics.
	hitT wallHit;

	// ====================
	// Frame timing
	// ====================

	frameTicker ticker (
		.clk          (clk),
		.resetN       (resetN),
		.startOfFrame (startOfFrame)
	);

	// ====================
	// Ball motion
	// ====================

	ballPhysics physics (
		.clk          (clk),
		.resetN       (resetN),
		.startOfFrame (startOfFrame),
		.pause        (pause),
		.levelReset   (levelReset),
		.launch       (launch),
		.wallHit      (wallHit),
		.ballPos      (ballPos)
	);

	// Playfield walls.
	wallCollision walls (
		.clk     (clk),
		.resetN  (resetN),
		.ballPos (ballPos),
		.wallHit (wallHit)
	);

endmodule

`default_nettype wire

// ==== pinball_asserts.sv ====
`default_nettype none

`include "pinball_cfg.svh"

module pinballAsserts
	import pinballPkg::*;
(
	input logic    clk,
	input logic    resetN,
	input logic    startOfFrame,
	input ballPosT ballPos,
	input hitT     wallHit
);

	timeunit 1ns;
	timeprecision 100ps;

	// Failed assertion count.
	int failCount = 0;

	// ====================
	// Frame pulse
	// ====================

	frameOnce: assert property (@(posedge clk) disable iff (!resetN)
		startOfFrame |=> !startOfFrame)
		else begin
			failCount++;
			$error("startOfFrame stayed high for two cycles");
		end

	// Field plus one ball size.
	xInField: assert property (@(posedge clk) disable iff (!resetN)
		(ballPos.x >= coordT'(-`BALL_SIZE)) && (ballPos.x <= coordT'(`FIELD_W + `BALL_SIZE)))
		else begin
			failCount++;
			$error("ballPos.x left the playfield");
		end

	yInField: assert property (@(posedge clk) disable iff (!resetN)
		(ballPos.y >= coordT'(-`BALL_SIZE)) && (ballPos.y <= coordT'(`FIELD_H + `BALL_SIZE)))
		else begin
			failCount++;
			$error("ballPos.y left the playfield");
		end

	hitQuietInReset: assert property (@(posedge clk) !resetN |-> (wallHit == '0))
		else begin
			failCount++;
			$error("wallHit active during reset");
		end

endmodule

bind pinballTop pinballAsserts checks (
	.clk          (clk),
	.resetN       (resetN),
	.startOfFrame (startOfFrame),
	.ballPos      (ballPos),
	.wallHit      (wallHit)
);

`default_nettype wire

// ==== pinball_cfg.svh ====
`ifndef PINBALL_CFG_SVH
`define PINBALL_CFG_SVH

// ====================
// Fixed point
// ====================

// Six fraction bits.
`define FIXED_SCALE 64

// Speed added to vertical speed every frame.
`define GRAVITY 8

// ====================
// Playfield
// ====================

`define FIELD_W 320
`define FIELD_H 240

// Side of the ball box, in pixels.
`define BALL_SIZE 8

// Top-left corner at level start.
`define START_X 300
`define START_Y 200

// Clock cycles per frame.
`define FRAME_CYCLES 16

// Vector widths.
`define COORD_W 11
`define SPEED_W 16

`endif

// ==== wallCollision.sv ====
`default_nettype none

`include "pinball_cfg.svh"

module wallCollision
	import pinballPkg::*;
(
	input  logic    clk,
	input  logic    resetN,
	input  ballPosT ballPos,
	output hitT     wallHit
);

	// ====================
	// Wall limits
	// ====================

	// Smallest top-left corner that touches the right or bottom wall.
	localparam coordT rightLimit  = coordT'(`FIELD_W - `BALL_SIZE);
	localparam coordT bottomLimit = coordT'(`FIELD_H - `BALL_SIZE);

	logic touchLeft;
	logic touchTop;
	logic touchRight;
	logic touchBottom;

	edgeCodeT edgesNext;

	// ====================
	// Edge compare
	// ====================

	// All four walls in parallel.
	always_comb begin
		touchLeft   = (ballPos.x <= coordT'(0));
		touchTop    = (ballPos.y <= coordT'(0));
		touchRight  = (ballPos.x >= rightLimit);
		touchBottom = (ballPos.y >= bottomLimit);
	end

	assign edgesNext = {touchLeft, touchTop, touchRight, touchBottom};

	// ====================
	// Registered event
	// ====================

	// Keeps the compare path away from the speed update.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			wallHit <= '0;
		end else begin
			wallHit.edges <= edgesNext;
			wallHit.hit   <= |edgesNext;
		end
	end

endmodule

`default_nettype wire
